//--- hw/ahb_defs.svh
`ifndef AHB_DEFS_SVH
`define AHB_DEFS_SVH

// ------------------------------
// Bus widths
// ------------------------------

// Byte address width on every layer and on the slave side
`define AHB_ADDR_W 32

// Read and write data width
`define AHB_DATA_W 32

// ------------------------------
// Matrix shape
// ------------------------------

// Upstream AHB layers sharing the slave
`define NUM_PORTS 2

// Memory depth in 32-bit words
// Byte addresses at or above 4 * MEM_WORDS get an ERROR response
`define MEM_WORDS 256

`endif

//--- hw/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

  // HTRANS encoding
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,  // No transfer
    HTRANS_BUSY   = 2'b01,  // Gap inside a burst
    HTRANS_NONSEQ = 2'b10,  // Single or first beat
    HTRANS_SEQ    = 2'b11   // Later beats of a burst
  } htrans_t;

  // HBURST encoding
  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,  // Undefined length
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_t;

  // HSIZE encoding, memory only handles words
  typedef enum logic [2:0] {
    HSIZE_BYTE   = 3'b000,
    HSIZE_HALF   = 3'b001,
    HSIZE_WORD   = 3'b010,
    HSIZE_DWORD  = 3'b011,
    HSIZE_4WORD  = 3'b100,
    HSIZE_8WORD  = 3'b101,
    HSIZE_16WORD = 3'b110,
    HSIZE_32WORD = 3'b111
  } hsize_t;

  // HRESP encoding
  typedef enum logic [1:0] {
    HRESP_OKAY  = 2'b00,
    HRESP_ERROR = 2'b01   // Always two cycles
  } hresp_t;

endpackage

`default_nettype wire

//--- hw/matrix_pkg.sv
`default_nettype none

`include "ahb_defs.svh"

package matrix_pkg;

  // One address phase as it travels through the matrix
  typedef struct packed {
    logic                   sel;    // HSEL
    logic [`AHB_ADDR_W-1:0] addr;   // Byte address
    ahb_pkg::htrans_t       trans;
    logic                   write;  // 1 for write
    ahb_pkg::hsize_t        size;
    ahb_pkg::hburst_t       burst;
  } addr_ctrl_t;

  // Slave feedback to a layer
  typedef struct packed {
    logic             readyout;  // HREADYOUT
    ahb_pkg::hresp_t  resp;      // HRESP
  } slave_rsp_t;

  // Address phase driven when nobody owns the slave
  localparam addr_ctrl_t IDLE_REQ = '{
    sel:   1'b0,
    addr:  '0,
    trans: ahb_pkg::HTRANS_IDLE,
    write: 1'b0,
    size:  ahb_pkg::HSIZE_WORD,
    burst: ahb_pkg::HBURST_SINGLE
  };

endpackage

`default_nettype wire

//--- hw/ahb_in_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_in_stage (
  input  wire logic                   HCLK,
  input  wire logic                   HRESETn,
  input  wire matrix_pkg::addr_ctrl_t layer_req,    // Address phase from the layer
  input  wire logic                   layer_ready,  // Layer HREADY
  input  wire logic                   active,       // Our stage_req is on the slave
  input  wire matrix_pkg::slave_rsp_t slave_rsp,
  output logic                        held_tran,    // Request to the arbiter
  output matrix_pkg::addr_ctrl_t      stage_req,
  output matrix_pkg::slave_rsp_t      layer_rsp     // HREADYOUT / HRESP to the layer
);

  // ------------------------------
  // Local signals
  // ------------------------------

  matrix_pkg::addr_ctrl_t hold_q;      // Holding register
  logic                   pend_q;      // Held transfer not yet issued
  logic                   pend_d;
  logic                   data_valid_q; // Layer is in a data phase to us
  logic                   addr_valid;
  logic                   load_reg;

  // Real transfer on the layer, IDLE and BUSY excluded
  assign addr_valid = layer_req.sel &&
                      (layer_req.trans == ahb_pkg::HTRANS_NONSEQ ||
                       layer_req.trans == ahb_pkg::HTRANS_SEQ);

  assign load_reg = addr_valid && layer_ready;  // Accepted this edge

  // Capture every accepted phase, only read back while pending
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
      hold_q <= layer_req;
  end

  // Data phase tracking follows the layer HREADY
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid_q <= 1'b0;
    else if (layer_ready)
      data_valid_q <= addr_valid;
  end

  // ------------------------------
  // Pending transfer
  // ------------------------------

  // Stays set until the slave takes our phase
  assign pend_d = held_tran && !(active && slave_rsp.readyout);

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_q <= 1'b0;
    else
      pend_q <= pend_d;
  end

  assign held_tran = load_reg || pend_q;  // New phase or parked one

  // Held phase replayed as a fresh NONSEQ
  always_comb
  begin
    if (pend_q)
    begin
      stage_req       = hold_q;
      stage_req.sel   = 1'b1;
      stage_req.trans = ahb_pkg::HTRANS_NONSEQ;  // SEQ beat restarts cleanly
    end
    else
      stage_req = layer_req;  // Straight through
  end

  // ------------------------------
  // Layer response
  // ------------------------------

  always_comb
  begin
    if (!data_valid_q)
    begin
      layer_rsp.readyout = 1'b1;  // Idle layer never waits
      layer_rsp.resp     = ahb_pkg::HRESP_OKAY;
    end
    else if (pend_q)
    begin
      layer_rsp.readyout = 1'b0;  // Stall until issued
      layer_rsp.resp     = ahb_pkg::HRESP_OKAY;
    end
    else
      layer_rsp = slave_rsp;  // Our data phase on the slave
  end

endmodule

`default_nettype wire

//--- hw/ahb_out_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_defs.svh"

module ahb_out_arbiter (
  input  wire logic                   HCLK,
  input  wire logic                   HRESETn,
  input  wire logic [`NUM_PORTS-1:0]  held_tran,
  input  wire matrix_pkg::addr_ctrl_t stage_req  [`NUM_PORTS],
  input  wire logic [`AHB_DATA_W-1:0] port_wdata [`NUM_PORTS],
  input  wire matrix_pkg::slave_rsp_t slave_rsp,
  output logic [`NUM_PORTS-1:0]       active,
  output matrix_pkg::addr_ctrl_t      mem_req,
  output logic [`AHB_DATA_W-1:0]      mem_wdata
);

  localparam int OWNER_W = $clog2(`NUM_PORTS);

  // ------------------------------
  // Local signals
  // ------------------------------

  logic [OWNER_W-1:0]     dph_owner_q;  // Owner of the phase now in data phase
  logic [OWNER_W-1:0]     pick;         // Fixed-priority winner
  logic [OWNER_W-1:0]     grant;        // Address phase owner this cycle
  logic                   any_req;
  logic                   burst_lock;
  matrix_pkg::addr_ctrl_t owner_req;    // Current request of the last owner

  assign any_req = |held_tran;

  // Lowest index wins, scan from the top so port 0 lands last
  always_comb
  begin
    pick = '0;
    for (int i = `NUM_PORTS - 1; i >= 0; i--)
    begin
      if (held_tran[i])
        pick = OWNER_W'(i);
    end
  end

  // ------------------------------
  // Burst lock
  // ------------------------------

  // Owner keeps the slave through SEQ and BUSY beats
  assign owner_req  = stage_req[dph_owner_q];
  assign burst_lock = owner_req.sel &&
                      (owner_req.trans == ahb_pkg::HTRANS_SEQ ||
                       owner_req.trans == ahb_pkg::HTRANS_BUSY);

  assign grant = burst_lock ? dph_owner_q : pick;

  // Owner only moves on when the slave finishes a data phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      dph_owner_q <= '0;
    else if (slave_rsp.readyout)
      dph_owner_q <= grant;
  end

  // ------------------------------
  // Slave side
  // ------------------------------

  // Address phase mux
  always_comb
  begin
    if (burst_lock || any_req)
      mem_req = stage_req[grant];  // Includes BUSY of a locked burst
    else
      mem_req = matrix_pkg::IDLE_REQ;
  end

  // Write data belongs to the data-phase owner
  assign mem_wdata = port_wdata[dph_owner_q];

  // Only a requesting owner is told it is on the slave
  always_comb
  begin
    for (int i = 0; i < `NUM_PORTS; i++)
      active[i] = held_tran[i] && (grant == OWNER_W'(i));
  end

endmodule

`default_nettype wire

//--- hw/ahb_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_defs.svh"

module ahb_mem_slave (
  input  wire logic                   HCLK,
  input  wire logic                   HRESETn,
  input  wire matrix_pkg::addr_ctrl_t mem_req,
  input  wire logic [`AHB_DATA_W-1:0] mem_wdata,
  output matrix_pkg::slave_rsp_t      slave_rsp,
  output logic [`AHB_DATA_W-1:0]      rdata
);

  localparam int                     WORD_AW   = $clog2(`MEM_WORDS);
  localparam logic [`AHB_ADDR_W-1:0] MEM_BYTES = 4 * `MEM_WORDS;

  logic [`AHB_DATA_W-1:0] mem [`MEM_WORDS];  // Word storage

  logic               dph_valid_q;   // OKAY data phase in progress
  logic               dph_write_q;
  logic [WORD_AW-1:0] dph_addr_q;    // Word index of the data phase
  logic               err_first_q;   // ERROR cycle with readyout low
  logic               err_second_q;  // ERROR cycle with readyout high
  logic               addr_valid;
  logic               in_range;
  logic               accept;

  assign addr_valid = mem_req.sel &&
                      (mem_req.trans == ahb_pkg::HTRANS_NONSEQ ||
                       mem_req.trans == ahb_pkg::HTRANS_SEQ);
  assign in_range   = mem_req.addr < MEM_BYTES;
  assign accept     = addr_valid && slave_rsp.readyout;  // Own HREADY

  // ------------------------------
  // Control
  // ------------------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      dph_valid_q  <= 1'b0;
      err_first_q  <= 1'b0;
      err_second_q <= 1'b0;
    end
    else
    begin
      dph_valid_q  <= accept && in_range;
      err_first_q  <= accept && !in_range;  // Bad address starts ERROR
      err_second_q <= err_first_q;
    end
  end

  // Address phase payload
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      dph_addr_q  <= mem_req.addr[WORD_AW+1:2];
      dph_write_q <= mem_req.write;
    end
  end

  // Store at the end of a write data phase
  always_ff @(posedge HCLK)
  begin
    if (dph_valid_q && dph_write_q)
      mem[dph_addr_q] <= mem_wdata;
  end

  assign rdata = mem[dph_addr_q];  // Zero-wait read

  assign slave_rsp.readyout = !err_first_q;
  assign slave_rsp.resp     = (err_first_q || err_second_q) ? ahb_pkg::HRESP_ERROR
                                                            : ahb_pkg::HRESP_OKAY;

endmodule

`default_nettype wire

//--- hw/ahb_shared_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_defs.svh"

module ahb_shared_mem_top (
  input  wire logic                   HCLK,
  input  wire logic                   HRESETn,
  input  wire matrix_pkg::addr_ctrl_t port_req   [`NUM_PORTS],
  input  wire logic [`AHB_DATA_W-1:0] port_wdata [`NUM_PORTS],
  output matrix_pkg::slave_rsp_t      port_rsp   [`NUM_PORTS],
  output logic [`AHB_DATA_W-1:0]      port_rdata            // Shared by all layers
);

  logic [`NUM_PORTS-1:0]  held_tran;
  logic [`NUM_PORTS-1:0]  active;
  matrix_pkg::addr_ctrl_t stage_req [`NUM_PORTS];
  matrix_pkg::addr_ctrl_t mem_req;
  logic [`AHB_DATA_W-1:0] mem_wdata;
  matrix_pkg::slave_rsp_t slave_rsp;

  // One input stage per layer
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : g_port
    ahb_in_stage u_in_stage (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .layer_req   (port_req[i]),
      .layer_ready (port_rsp[i].readyout),  // Single-slave layer sees its own HREADYOUT
      .active      (active[i]),
      .slave_rsp   (slave_rsp),
      .held_tran   (held_tran[i]),
      .stage_req   (stage_req[i]),
      .layer_rsp   (port_rsp[i])
    );
  end

  ahb_out_arbiter u_arbiter (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .held_tran  (held_tran),
    .stage_req  (stage_req),
    .port_wdata (port_wdata),
    .slave_rsp  (slave_rsp),
    .active     (active),
    .mem_req    (mem_req),
    .mem_wdata  (mem_wdata)
  );

  ahb_mem_slave u_mem (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .mem_req   (mem_req),
    .mem_wdata (mem_wdata),
    .slave_rsp (slave_rsp),
    .rdata     (port_rdata)
  );

endmodule

`default_nettype wire

//--- tests/ahb_arbiter_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_defs.svh"

module ahb_out_arbiter_assertions (
  input wire logic                               HCLK,
  input wire logic                               HRESETn,
  input wire logic [`NUM_PORTS-1:0]              active,
  input wire logic [$clog2(`NUM_PORTS)-1:0]      dph_owner_q,
  input wire matrix_pkg::addr_ctrl_t             owner_req,   // Owner's current request
  input wire matrix_pkg::addr_ctrl_t             mem_req,     // Address phase on the slave
  input wire matrix_pkg::slave_rsp_t             slave_rsp
);

  logic in_burst;
  logic slave_take;

  // Owner in the middle of a burst
  assign in_burst = owner_req.sel &&
                    (owner_req.trans == ahb_pkg::HTRANS_SEQ ||
                     owner_req.trans == ahb_pkg::HTRANS_BUSY);

  // Slave takes an address phase at this edge
  assign slave_take = mem_req.sel &&
                      (mem_req.trans == ahb_pkg::HTRANS_NONSEQ ||
                       mem_req.trans == ahb_pkg::HTRANS_SEQ) &&
                      slave_rsp.readyout;

  // A phase the slave takes belongs to exactly one port
  a_one_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(active) && (!slave_take || $onehot(active)))
    else $error("Active ports do not match the address phase taken by the slave");

  a_burst_owner: assert property (@(posedge HCLK) disable iff (!HRESETn)
    in_burst |=> $stable(dph_owner_q))
    else $error("Owner changed during a SEQ or BUSY beat");

  // First ERROR cycle is followed by the ready one
  a_error_second: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (slave_rsp.resp == ahb_pkg::HRESP_ERROR && !slave_rsp.readyout)
    |=> (slave_rsp.resp == ahb_pkg::HRESP_ERROR && slave_rsp.readyout))
    else $error("ERROR response did not finish in its second cycle");

  a_error_first: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (slave_rsp.resp == ahb_pkg::HRESP_ERROR && slave_rsp.readyout)
    |-> $past(slave_rsp.resp == ahb_pkg::HRESP_ERROR && !slave_rsp.readyout))
    else $error("ERROR response with readyout high lacked its first cycle");

endmodule

bind ahb_out_arbiter ahb_out_arbiter_assertions u_arbiter_assertions (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .active      (active),
  .dph_owner_q (dph_owner_q),
  .owner_req   (owner_req),
  .mem_req     (mem_req),
  .slave_rsp   (slave_rsp)
);

`default_nettype wire

//--- tests/tb_ahb_shared_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_defs.svh"

module tb_ahb_shared_mem;

  localparam int TIMEOUT = 40;                    // Max cycles of one wait
  localparam int WORD_AW = $clog2(`MEM_WORDS);

  logic                   HCLK;
  logic                   HRESETn;
  matrix_pkg::addr_ctrl_t port_req   [`NUM_PORTS];
  logic [`AHB_DATA_W-1:0] port_wdata [`NUM_PORTS];
  matrix_pkg::slave_rsp_t port_rsp   [`NUM_PORTS];
  logic [`AHB_DATA_W-1:0] port_rdata;

  logic [`AHB_DATA_W-1:0] ref_mem   [`MEM_WORDS];  // Reference memory
  logic                   ref_valid [`MEM_WORDS];  // Word written at least once
  logic [31:0]            lfsr;
  logic [`AHB_DATA_W-1:0] beat_data [4];           // INCR4 payload
  int                     errors;
  int                     timeouts;
  int                     checks;

  // Outcome of the last transfer per port
  logic [`AHB_DATA_W-1:0] last_rdata   [`NUM_PORTS];
  ahb_pkg::hresp_t        last_resp    [`NUM_PORTS];
  int                     last_stalls  [`NUM_PORTS];  // Readyout low cycles
  logic                   last_low_err [`NUM_PORTS];  // ERROR seen with readyout low
  time                    done_time    [`NUM_PORTS];

  ahb_shared_mem_top DUT (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .port_req   (port_req),
    .port_wdata (port_wdata),
    .port_rsp   (port_rsp),
    .port_rdata (port_rdata)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;  // 40 ns period
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [WORD_AW-1:0] word_of(input logic [31:0] addr);
    return addr[WORD_AW+1:2];
  endfunction

  function automatic matrix_pkg::addr_ctrl_t make_req(input logic [31:0] addr,
      input logic wr, input ahb_pkg::htrans_t trans, input ahb_pkg::hburst_t burst);
    matrix_pkg::addr_ctrl_t r;
    r.sel   = 1'b1;
    r.addr  = addr;
    r.trans = trans;
    r.write = wr;
    r.size  = ahb_pkg::HSIZE_WORD;
    r.burst = burst;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Returns at the negedge before the edge where readyout is high
  task automatic wait_ready(input int p, input string what);
    int n;
    n = 0;
    @(negedge HCLK);
    while (!port_rsp[p].readyout && n < TIMEOUT)
    begin
      if (port_rsp[p].resp == ahb_pkg::HRESP_ERROR)
        last_low_err[p] = 1'b1;
      n++;
      @(negedge HCLK);
    end
    last_stalls[p] += n;
    if (!port_rsp[p].readyout)
    begin
      timeouts++;
      $display("Timeout: port %0d saw readyout low for %0d cycles in the %s", p, n, what);
    end
  endtask

  // One NONSEQ SINGLE transfer, address phase then data phase
  task automatic single_xfer(input int p, input logic [31:0] addr, input logic wr,
                             input logic [31:0] wd);
    last_stalls[p]  = 0;
    last_low_err[p] = 1'b0;
    @(posedge HCLK);
    port_req[p] <= make_req(addr, wr, ahb_pkg::HTRANS_NONSEQ, ahb_pkg::HBURST_SINGLE);
    wait_ready(p, "address phase");
    @(posedge HCLK);                       // Address accepted
    port_req[p]   <= matrix_pkg::IDLE_REQ;
    port_wdata[p] <= wd;                   // Held through the data phase
    wait_ready(p, "data phase");
    last_rdata[p] = port_rdata;
    last_resp[p]  = port_rsp[p].resp;
    done_time[p]  = $time;
  endtask

  // Pipelined INCR4 write of beat_data
  task automatic burst_write(input int p, input logic [31:0] base);
    last_stalls[p]  = 0;
    last_low_err[p] = 1'b0;
    @(posedge HCLK);
    port_req[p] <= make_req(base, 1'b1, ahb_pkg::HTRANS_NONSEQ, ahb_pkg::HBURST_INCR4);
    for (int b = 0; b < 4; b++)
    begin
      wait_ready(p, "burst beat");
      @(posedge HCLK);
      if (b < 3)
        port_req[p] <= make_req(base + 32'(4 * (b + 1)), 1'b1, ahb_pkg::HTRANS_SEQ,
                                ahb_pkg::HBURST_INCR4);
      else
        port_req[p] <= matrix_pkg::IDLE_REQ;
      port_wdata[p] <= beat_data[b];     // Data of the beat just accepted
    end
    wait_ready(p, "last burst data phase");
    last_resp[p] = port_rsp[p].resp;
    done_time[p] = $time;
  endtask

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
    ref_mem[word_of(addr)]   = data;
    ref_valid[word_of(addr)] = 1'b1;
  endtask

  task automatic write_word(input int p, input logic [31:0] addr, input logic [31:0] data,
                            input string name);
    single_xfer(p, addr, 1'b1, data);
    check_value({name, "_resp"}, 32'(ahb_pkg::HRESP_OKAY), 32'(last_resp[p]));
    model_write(addr, data);
  endtask

  task automatic read_check(input int p, input logic [31:0] addr, input string name);
    single_xfer(p, addr, 1'b0, '0);
    check_value({name, "_resp"}, 32'(ahb_pkg::HRESP_OKAY), 32'(last_resp[p]));
    check_value(name, ref_mem[word_of(addr)], last_rdata[p]);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic single_port_rw(input int p, input logic [31:0] addr, input string name);
    write_word(p, addr, rand_bits(32), {name, "_write"});
    read_check(p, addr, {name, "_read"});
  endtask

  // Port 0 wins, port 1 gets parked
  task automatic same_edge_writes();
    logic [31:0] d0;
    logic [31:0] d1;
    d0 = rand_bits(32);
    d1 = rand_bits(32);
    fork
      single_xfer(0, 32'h20, 1'b1, d0);
      single_xfer(1, 32'h24, 1'b1, d1);
    join
    check_value("t3_port0_resp", 32'(ahb_pkg::HRESP_OKAY), 32'(last_resp[0]));
    check_value("t3_port1_resp", 32'(ahb_pkg::HRESP_OKAY), 32'(last_resp[1]));
    check_value("t3_port1_stalled", 32'd1, 32'(last_stalls[1] > 0));
    model_write(32'h20, d0);
    model_write(32'h24, d1);
    read_check(0, 32'h20, "t3_read_port0_word");
    read_check(1, 32'h24, "t3_read_port1_word");
  endtask

  task automatic burst_lock_writes();
    logic [31:0] d1;
    for (int b = 0; b < 4; b++)
      beat_data[b] = rand_bits(32);
    d1 = rand_bits(32);
    fork
      burst_write(0, 32'h40);
      begin
        @(posedge HCLK);                   // Lands in the second beat
        single_xfer(1, 32'h80, 1'b1, d1);
      end
    join
    check_value("t4_burst_resp", 32'(ahb_pkg::HRESP_OKAY), 32'(last_resp[0]));
    check_value("t4_port1_resp", 32'(ahb_pkg::HRESP_OKAY), 32'(last_resp[1]));
    check_value("t4_port1_after_burst", 32'd1, 32'(done_time[1] > done_time[0]));
    for (int b = 0; b < 4; b++)
      model_write(32'h40 + 32'(4 * b), beat_data[b]);
    model_write(32'h80, d1);
    for (int b = 0; b < 4; b++)
      read_check(b % 2, 32'h40 + 32'(4 * b), "t4_read_burst_word");
    read_check(1, 32'h80, "t4_read_port1_word");
  endtask

  task automatic error_response();
    single_xfer(0, 32'(4 * `MEM_WORDS), 1'b1, rand_bits(32));  // First byte past memory
    check_value("t5_error_with_low_ready", 32'd1, 32'(last_low_err[0]));
    check_value("t5_error_wait_cycles", 32'd1, 32'(last_stalls[0]));
    check_value("t5_error_final_resp", 32'(ahb_pkg::HRESP_ERROR), 32'(last_resp[0]));
    read_check(0, 32'h0, "t5_word0_after_error");
  endtask

  task automatic random_mix();
    logic [31:0]        r;
    logic [WORD_AW-1:0] w;
    logic [31:0]        addr;
    for (int k = 0; k < 40; k++)
    begin
      r    = rand_bits(WORD_AW);
      w    = r[WORD_AW-1:0];
      addr = {{(`AHB_ADDR_W - WORD_AW - 2){1'b0}}, w, 2'b00};
      r    = rand_bits(1);
      if (r[0] || !ref_valid[w])           // Never read a word the model lacks
        write_word(k % 2, addr, rand_bits(32), "t6_random_write");
      else
        read_check(k % 2, addr, "t6_random_read");
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial
  begin
    HRESETn  = 1'b0;
    lfsr     = 32'h47aa;
    errors   = 0;
    timeouts = 0;
    checks   = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      port_req[i]   = matrix_pkg::IDLE_REQ;
      port_wdata[i] = '0;
    end
    for (int i = 0; i < `MEM_WORDS; i++)
      ref_valid[i] = 1'b0;

    repeat (2) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      check_value("reset_readyout", 32'd1, 32'(port_rsp[i].readyout));
      check_value("reset_resp", 32'(ahb_pkg::HRESP_OKAY), 32'(port_rsp[i].resp));
    end

    single_port_rw(0, 32'h0, "t1_port0");
    single_port_rw(1, 32'h10, "t2_port1");
    same_edge_writes();
    burst_lock_writes();
    error_response();
    random_mix();

    $display("Checks: %0d  mismatches: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/ahb_pkg.sv
hw/matrix_pkg.sv
hw/ahb_in_stage.sv
hw/ahb_out_arbiter.sv
hw/ahb_mem_slave.sv
hw/ahb_shared_mem_top.sv
tests/ahb_arbiter_assertions.sv
tests/tb_ahb_shared_mem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ahb_shared_mem
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
